//--- Makefile
# Verilator build and run of the stream bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_hw_accel_stream
FILELIST  ?= hw_accel_stream.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/hw_accel_stream_sva.sv
// DMA framing and register read timing checks, bound into the top level
// all checks sampled on the rising edge, idle while reset is high
`timescale 1ns/1ns
`default_nettype none

module hw_accel_stream_sva (
   input logic                        clk,
   input logic                        rst,
   input logic                        wready_i,
   input stream_types_pkg::dma_beat_t beat_i,
   input logic                        re_i,
   input logic                        rvalid_i
);

   ////////////////////
   // DMA framing
   ////////////////////

   // last flag only rides on a real beat
   a_last_with_valid: assert property (
      @(posedge clk) disable iff (rst) beat_i.wlast |-> beat_i.wvalid
   ) else $error("wlast high without wvalid");

   // output FIFO pops only into a ready sink
   a_valid_needs_ready: assert property (
      @(posedge clk) disable iff (rst) beat_i.wvalid |-> wready_i
   ) else $error("wvalid high while wready low");

   ////////////////////
   // register reads
   ////////////////////

   // one-cycle read latency
   a_rvalid_follows_re: assert property (
      @(posedge clk) disable iff (rst) re_i |=> rvalid_i
   ) else $error("rvalid missing one cycle after read strobe");

   // no spurious read response
   a_rvalid_only_after_re: assert property (
      @(posedge clk) disable iff (rst) rvalid_i |-> $past(re_i)
   ) else $error("rvalid without a read strobe one cycle before");

endmodule

`default_nettype wire

//--- bench/tb_hw_accel_stream.sv
// directed testbench for a DUT built with TRANSFER_LEN of 8
// inputs driven on the rising edge and outputs sampled on the falling edge
`timescale 1ns/1ns
`default_nettype none

`include "accel_consts.svh"

module tb_hw_accel_stream;

   localparam int XFER_BEATS  = 8;
   localparam int XFER_WORDS  = 4;
   localparam int OVF_WORDS   = 100;
   localparam int TOTAL_BEATS = 3 * XFER_BEATS;
   // back-pressure roughly halves the beat rate
   localparam int CYCLE_LIMIT = 100 + 8 * (TOTAL_BEATS + 3 * XFER_WORDS + OVF_WORDS);

   logic                           clk;
   logic                           rst;
   logic                           stream_wr_en_i;
   stream_types_pkg::stream_word_t stream_wr_data_i;
   ctrl_types_pkg::reg_write_t     reg_wr_i;
   logic                           reg_re_i;
   ctrl_types_pkg::reg_addr_e      reg_raddr_i;
   logic [31:0]                    reg_rdata_o;
   logic                           reg_rvalid_o;
   logic                           dma_wready_i;
   stream_types_pkg::dma_beat_t    dma_beat_o;

   // bookkeeping
   logic [31:0]                 lcg_state = 32'h7896;
   stream_types_pkg::dma_beat_t beat_q[$];
   int                          err_count = 0;
   int                          tests_run = 0;
   int                          tests_failed = 0;
   int                          writes_total = 0;
   int                          beats_expected = 0;
   int                          beats_seen = 0;
   int                          cycle_count = 0;
   logic                        re_seen = 1'b0;

   hw_accel_stream #(
      .TRANSFER_LEN (XFER_BEATS)
   ) u_dut (
      .clk              (clk),
      .rst              (rst),
      .stream_wr_en_i   (stream_wr_en_i),
      .stream_wr_data_i (stream_wr_data_i),
      .reg_wr_i         (reg_wr_i),
      .reg_re_i         (reg_re_i),
      .reg_raddr_i      (reg_raddr_i),
      .reg_rdata_o      (reg_rdata_o),
      .reg_rvalid_o     (reg_rvalid_o),
      .dma_wready_i     (dma_wready_i),
      .dma_beat_o       (dma_beat_o)
   );

   bind hw_accel_stream hw_accel_stream_sva u_sva (
      .clk      (clk),
      .rst      (rst),
      .wready_i (dma_wready_i),
      .beat_i   (dma_beat_o),
      .re_i     (reg_re_i),
      .rvalid_i (reg_rvalid_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // watchdog
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   ////////////////////
   // helpers
   ////////////////////

   // full-period 32-bit LCG
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic stream_types_pkg::pixel_t random_pixel();
      logic [31:0] rnd;
      rnd = lcg_next();
      return rnd[23:0];
   endfunction

   // (r + 2g + b) / 4 onto every channel
   function automatic stream_types_pkg::pixel_t to_gray(input stream_types_pkg::pixel_t p);
      int                       luma;
      stream_types_pkg::pixel_t q;
      luma = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
      q.r  = luma[7:0];
      q.g  = luma[7:0];
      q.b  = luma[7:0];
      return q;
   endfunction

   task automatic note_error(input string msg);
      $display("%s", msg);
      err_count++;
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_pixel(input string name, input stream_types_pkg::pixel_t got,
                              input stream_types_pkg::pixel_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_beat(input string name, input stream_types_pkg::dma_beat_t got,
                             input stream_types_pkg::dma_beat_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (err_count == errs_before) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
      end
   endtask

   // one-cycle write strobe
   task automatic write_reg(input ctrl_types_pkg::reg_addr_e addr, input logic [31:0] data);
      ctrl_types_pkg::reg_write_t wr;
      wr.we    = 1'b1;
      wr.addr  = addr;
      wr.wdata = data;
      @(posedge clk);
      reg_wr_i <= wr;
      @(posedge clk);
      reg_wr_i.we <= 1'b0;
   endtask

   // response is due one cycle after the strobe
   task automatic read_check(input string name, input ctrl_types_pkg::reg_addr_e addr,
                             input logic [31:0] exp);
      @(posedge clk);
      reg_re_i    <= 1'b1;
      reg_raddr_i <= addr;
      @(posedge clk);
      reg_re_i <= 1'b0;
      @(negedge clk);
      if (reg_rvalid_o !== 1'b1) begin
         note_error($sformatf("read of %s returned no rvalid one cycle after the strobe", name));
      end else begin
         check_word(name, reg_rdata_o, exp);
      end
   endtask

   ////////////////////
   // output monitor
   ////////////////////
   always @(negedge clk) begin
      if (!rst) begin
         if (dma_beat_o.wlast && !dma_beat_o.wvalid) begin
            note_error("wlast was high without wvalid");
         end
         if (dma_beat_o.wvalid && !dma_wready_i) begin
            note_error("a beat appeared while wready was low");
         end
         if (reg_rvalid_o !== re_seen) begin
            note_error("reg_rvalid_o did not follow the read strobe by one cycle");
         end
         re_seen = reg_re_i;
         if (dma_beat_o.wvalid) begin
            beat_q.push_back(dma_beat_o);
            beats_seen++;
         end
      end
   end

   ////////////////////
   // tests
   ////////////////////
   task automatic test_readback();
      int errs_before;
      errs_before = err_count;
      read_check("reg_rdata_o signature", ctrl_types_pkg::REG_SIGNATURE, `ACCEL_SIGNATURE);
      write_reg(ctrl_types_pkg::REG_MODE, 32'd1);
      read_check("reg_rdata_o mode gray", ctrl_types_pkg::REG_MODE, 32'd1);
      write_reg(ctrl_types_pkg::REG_MODE, 32'd0);
      read_check("reg_rdata_o mode pass", ctrl_types_pkg::REG_MODE, 32'd0);
      read_check("reg_rdata_o unmapped", ctrl_types_pkg::reg_addr_e'(4'hF), 32'd0);
      report_test("register readback", errs_before);
   endtask

   // one armed transfer of XFER_WORDS stream words
   task automatic run_transfer(input string name, input ctrl_types_pkg::accel_mode_e mode,
                               input bit backpressure);
      stream_types_pkg::pixel_t       exp_pix[$];
      stream_types_pkg::stream_word_t word;
      stream_types_pkg::dma_beat_t    exp_beat;
      logic [31:0]                    rnd;
      int                             sent;
      int                             errs_before;
      errs_before = err_count;
      sent        = 0;
      write_reg(ctrl_types_pkg::REG_MODE, {31'd0, mode});
      write_reg(ctrl_types_pkg::REG_START, 32'd0);
      // start pulse follows the write by one cycle
      repeat (2) @(posedge clk);
      beat_q.delete();
      while (beat_q.size() < XFER_BEATS) begin
         @(posedge clk);
         if (sent < XFER_WORDS) begin
            word.lo = random_pixel();
            word.hi = random_pixel();
            // lo half leaves first
            if (mode == ctrl_types_pkg::MODE_GRAY) begin
               exp_pix.push_back(to_gray(word.lo));
               exp_pix.push_back(to_gray(word.hi));
            end else begin
               exp_pix.push_back(word.lo);
               exp_pix.push_back(word.hi);
            end
            stream_wr_en_i   <= 1'b1;
            stream_wr_data_i <= word;
            sent++;
            writes_total++;
         end else begin
            stream_wr_en_i <= 1'b0;
         end
         rnd = lcg_next();
         dma_wready_i <= backpressure ? rnd[16] : 1'b1;
      end
      @(posedge clk);
      stream_wr_en_i <= 1'b0;
      dma_wready_i   <= 1'b1;
      // framer should now be disarmed and quiet
      repeat (4) @(posedge clk);
      @(negedge clk);
      beats_expected += XFER_BEATS;
      if (beat_q.size() != XFER_BEATS) begin
         note_error($sformatf("%0d beats seen instead of %0d", beat_q.size(), XFER_BEATS));
      end
      for (int k = 0; k < beat_q.size() && k < XFER_BEATS; k++) begin
         exp_beat.wvalid = 1'b1;
         exp_beat.wlast  = (k == XFER_BEATS - 1);
         // zero byte above the pixel
         exp_beat.wdata  = {8'h00, exp_pix[k]};
         check_pixel($sformatf("dma_beat_o.wdata pixel %0d", k),
                     beat_q[k].wdata[`ACCEL_PIXEL_W-1:0], exp_pix[k]);
         check_beat($sformatf("dma_beat_o beat %0d", k), beat_q[k], exp_beat);
      end
      report_test(name, errs_before);
   endtask

   // without a start nothing drains and the input FIFO overruns
   task automatic test_overflow();
      stream_types_pkg::stream_word_t word;
      int                             errs_before;
      errs_before = err_count;
      for (int i = 0; i < OVF_WORDS; i++) begin
         @(posedge clk);
         word.lo = random_pixel();
         word.hi = random_pixel();
         stream_wr_en_i   <= 1'b1;
         stream_wr_data_i <= word;
         writes_total++;
      end
      @(posedge clk);
      stream_wr_en_i <= 1'b0;
      repeat (4) @(posedge clk);
      // only in_overflow in bit 1 since prog-full keeps the output FIFO below full
      read_check("reg_rdata_o status", ctrl_types_pkg::REG_STATUS, 32'd2);
      read_check("reg_rdata_o in_wcount", ctrl_types_pkg::REG_IN_WCOUNT, writes_total);
      read_check("reg_rdata_o out_rcount", ctrl_types_pkg::REG_OUT_RCOUNT, beats_expected);
      if (beats_seen != beats_expected) begin
         note_error($sformatf("%0d beats seen on the DMA port, %0d expected",
                              beats_seen, beats_expected));
      end
      report_test("overflow and counters", errs_before);
   endtask

   initial begin
      rst              = 1'b1;
      stream_wr_en_i   = 1'b0;
      stream_wr_data_i = '0;
      reg_wr_i         = '0;
      reg_re_i         = 1'b0;
      reg_raddr_i      = ctrl_types_pkg::REG_MODE;
      dma_wready_i     = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      repeat (2) @(posedge clk);

      test_readback();
      run_transfer("pass-through transfer", ctrl_types_pkg::MODE_PASS, 1'b0);
      run_transfer("grayscale transfer", ctrl_types_pkg::MODE_GRAY, 1'b0);
      run_transfer("back-pressure transfer", ctrl_types_pkg::MODE_PASS, 1'b1);
      test_overflow();

      $display("tests run: %0d, tests failed: %0d, check errors: %0d",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw_accel_stream.f
+incdir+logic
logic/stream_types_pkg.sv
logic/ctrl_types_pkg.sv
logic/sync_fifo.sv
logic/pixel_unpacker.sv
logic/gray_convert.sv
logic/dma_write_framer.sv
logic/accel_regs.sv
logic/hw_accel_stream.sv
bench/hw_accel_stream_sva.sv
bench/tb_hw_accel_stream.sv

//--- logic/accel_consts.svh
// widths, FIFO depths and transfer length shared by RTL and testbench
// FIFO depths must stay powers of two
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

////////////////////
// data widths
////////////////////

// one RGB pixel, 8 bits per channel
`define ACCEL_PIXEL_W 24
// input stream word carries two pixels
`define ACCEL_STREAM_W 48
// DMA write beat
`define ACCEL_DMA_W 32

////////////////////
// buffering
////////////////////

// input FIFO depth in stream words
`define ACCEL_IN_DEPTH 32
// output FIFO depth in pixels, prog-full at half
`define ACCEL_OUT_DEPTH 64

// default beats per DMA transfer
`define ACCEL_TRANSFER_LEN 1920

// readback check value
`define ACCEL_SIGNATURE 32'hABCD_1234

`endif

//--- logic/accel_regs.sv
// register block: mode, start pulse, sticky flags, traffic counters
// reads return data and rvalid one cycle after re_i
`timescale 1ns/1ns
`default_nettype none

`include "accel_consts.svh"

module accel_regs (
   input  logic                         clk,
   input  logic                         rst,
   input  ctrl_types_pkg::reg_write_t   wr_i,
   input  logic                         re_i,
   input  ctrl_types_pkg::reg_addr_e    raddr_i,
   output logic [31:0]                  rdata_o,
   output logic                         rvalid_o,
   input  ctrl_types_pkg::fifo_events_t events_i,
   output ctrl_types_pkg::accel_mode_e  mode_o,
   output logic                         start_o
);

   logic        in_ovf_flag;
   logic        out_ovf_flag;
   logic [31:0] in_wcount;
   logic [31:0] out_rcount;

   ////////////////////
   // writes
   ////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mode_o  <= ctrl_types_pkg::MODE_PASS;
         start_o <= 1'b0;
      end else begin
         // any value written to start arms a transfer
         start_o <= wr_i.we && (wr_i.addr == ctrl_types_pkg::REG_START);
         if (wr_i.we && (wr_i.addr == ctrl_types_pkg::REG_MODE)) begin
            mode_o <= ctrl_types_pkg::accel_mode_e'(wr_i.wdata[0]);
         end
      end
   end

   ////////////////////
   // flags, counters
   ////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         in_ovf_flag  <= 1'b0;
         out_ovf_flag <= 1'b0;
         in_wcount    <= '0;
         out_rcount   <= '0;
      end else begin
         // sticky until reset
         if (events_i.in_overflow) in_ovf_flag <= 1'b1;
         if (events_i.out_overflow) out_ovf_flag <= 1'b1;
         // counts every write strobe, dropped or not
         if (events_i.in_push) in_wcount <= in_wcount + 1'b1;
         if (events_i.out_pop) out_rcount <= out_rcount + 1'b1;
      end
   end

   ////////////////////
   // reads
   ////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= re_i;
      end
   end

   // read data, valid only with rvalid_o
   always_ff @(posedge clk) begin
      if (re_i) begin
         case (raddr_i)
            ctrl_types_pkg::REG_MODE:       rdata_o <= {31'd0, mode_o};
            ctrl_types_pkg::REG_SIGNATURE:  rdata_o <= `ACCEL_SIGNATURE;
            ctrl_types_pkg::REG_STATUS:     rdata_o <= {30'd0, in_ovf_flag, out_ovf_flag};
            ctrl_types_pkg::REG_IN_WCOUNT:  rdata_o <= in_wcount;
            ctrl_types_pkg::REG_OUT_RCOUNT: rdata_o <= out_rcount;
            // start and unmapped addresses read zero
            default:                        rdata_o <= 32'd0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/ctrl_types_pkg.sv
// control types: mode, register map, register write port, FIFO events
`default_nettype none

package ctrl_types_pkg;

   typedef enum logic [0:0] {
      MODE_PASS = 1'b0,
      MODE_GRAY = 1'b1
   } accel_mode_e;

   // word addresses of the register block
   typedef enum logic [3:0] {
      REG_MODE       = 4'd1,
      REG_START      = 4'd2,
      REG_SIGNATURE  = 4'd3,
      REG_STATUS     = 4'd4,
      REG_IN_WCOUNT  = 4'd5,
      REG_OUT_RCOUNT = 4'd6
   } reg_addr_e;

   // single-cycle write strobe
   typedef struct packed {
      logic        we;
      reg_addr_e   addr;
      logic [31:0] wdata;
   } reg_write_t;

   // datapath strobes reported to the register block
   typedef struct packed {
      logic in_push;
      logic in_overflow;
      logic out_overflow;
      logic out_pop;
   } fifo_events_t;

endpackage

`default_nettype wire

//--- logic/dma_write_framer.sv
// output FIFO and DMA write framing, wvalid is combinational
// start_i flushes the FIFO and arms one transfer of TRANSFER_LEN beats
`timescale 1ns/1ns
`default_nettype none

`include "accel_consts.svh"

module dma_write_framer #(
   parameter int TRANSFER_LEN = `ACCEL_TRANSFER_LEN
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         start_i,
   input  logic                         wready_i,
   input  stream_types_pkg::pixel_t     pix_i,
   input  logic                         pix_valid_i,
   output logic                         hold_o,
   output stream_types_pkg::dma_beat_t  beat_o,
   output logic                         overflow_o,
   output logic                         pop_o
);

   localparam int CNT_W = $clog2(TRANSFER_LEN + 1);
   localparam int OUT_CW = $clog2(`ACCEL_OUT_DEPTH) + 1;

   stream_types_pkg::pixel_t head_pix;
   logic                     fifo_empty;
   logic [OUT_CW-1:0]        fifo_count;
   logic                     armed;
   logic [CNT_W-1:0]         beat_cnt;
   logic                     last_beat;

   sync_fifo #(
      .WIDTH ($bits(stream_types_pkg::pixel_t)),
      .DEPTH (`ACCEL_OUT_DEPTH)
   ) u_out_fifo (
      .clk        (clk),
      .rst        (rst),
      .flush_i    (start_i),
      .push_i     (pix_valid_i),
      .pop_i      (pop_o),
      .wdata_i    (pix_i),
      .rdata_o    (head_pix),
      .empty_o    (fifo_empty),
      .count_o    (fifo_count),
      .overflow_o (overflow_o)
   );

   // prog-full, margin covers the converter stage
   assign hold_o = (fifo_count > OUT_CW'(`ACCEL_OUT_DEPTH / 2));

   ////////////////////
   // beat generation
   ////////////////////
   assign pop_o        = armed && wready_i && !fifo_empty;
   assign last_beat    = pop_o && (beat_cnt == CNT_W'(TRANSFER_LEN - 1));
   assign beat_o.wvalid = pop_o;
   assign beat_o.wlast  = last_beat;
   assign beat_o.wdata  = {{(`ACCEL_DMA_W - `ACCEL_PIXEL_W){1'b0}}, head_pix};

   // armed flag and beat counter
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         armed    <= 1'b0;
         beat_cnt <= '0;
      end else if (start_i) begin
         armed    <= 1'b1;
         beat_cnt <= '0;
      end else if (last_beat) begin
         // transfer done, wait for the next start
         armed    <= 1'b0;
         beat_cnt <= '0;
      end else if (pop_o) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- logic/gray_convert.sv
// one register stage, pass-through or grayscale per pixel
// mode is sampled as each pixel enters
`timescale 1ns/1ns
`default_nettype none

module gray_convert (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       flush_i,
   input  ctrl_types_pkg::accel_mode_e mode_i,
   input  stream_types_pkg::pixel_t   pix_i,
   input  logic                       valid_i,
   output stream_types_pkg::pixel_t   pix_o,
   output logic                       valid_o
);

   // r + 2g + b, max 1020 fits 10 bits
   logic [9:0] luma_sum;
   logic [7:0] luma;

   assign luma_sum = {2'b00, pix_i.r} + {1'b0, pix_i.g, 1'b0} + {2'b00, pix_i.b};
   // divide by 4, round down
   assign luma     = luma_sum[9:2];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_o <= 1'b0;
      end else if (flush_i) begin
         // drop the pixel in flight
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   // pixel payload
   always_ff @(posedge clk) begin
      if (valid_i) begin
         if (mode_i == ctrl_types_pkg::MODE_GRAY) begin
            pix_o.r <= luma;
            pix_o.g <= luma;
            pix_o.b <= luma;
         end else begin
            pix_o <= pix_i;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/hw_accel_stream.sv
// pixel stream to DMA write bridge, single clock
// no input back-pressure; start via register write flushes the datapath
`timescale 1ns/1ns
`default_nettype none

`include "accel_consts.svh"

module hw_accel_stream #(
   parameter int TRANSFER_LEN = `ACCEL_TRANSFER_LEN
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           stream_wr_en_i,
   input  stream_types_pkg::stream_word_t stream_wr_data_i,
   input  ctrl_types_pkg::reg_write_t     reg_wr_i,
   input  logic                           reg_re_i,
   input  ctrl_types_pkg::reg_addr_e      reg_raddr_i,
   output logic [31:0]                    reg_rdata_o,
   output logic                           reg_rvalid_o,
   input  logic                           dma_wready_i,
   output stream_types_pkg::dma_beat_t    dma_beat_o
);

   stream_types_pkg::pixel_t     unpack_pix;
   logic                         unpack_valid;
   stream_types_pkg::pixel_t     conv_pix;
   logic                         conv_valid;
   logic                         out_hold;
   logic                         in_ovf;
   logic                         out_ovf;
   logic                         out_pop;
   logic                         start;
   ctrl_types_pkg::accel_mode_e  mode;
   ctrl_types_pkg::fifo_events_t events;

   ////////////////////
   // datapath
   ////////////////////
   pixel_unpacker u_unpacker (
      .clk         (clk),
      .rst         (rst),
      .flush_i     (start),
      .push_i      (stream_wr_en_i),
      .word_i      (stream_wr_data_i),
      .hold_i      (out_hold),
      .pix_o       (unpack_pix),
      .pix_valid_o (unpack_valid),
      .overflow_o  (in_ovf)
   );

   gray_convert u_convert (
      .clk     (clk),
      .rst     (rst),
      .flush_i (start),
      .mode_i  (mode),
      .pix_i   (unpack_pix),
      .valid_i (unpack_valid),
      .pix_o   (conv_pix),
      .valid_o (conv_valid)
   );

   dma_write_framer #(
      .TRANSFER_LEN (TRANSFER_LEN)
   ) u_framer (
      .clk         (clk),
      .rst         (rst),
      .start_i     (start),
      .wready_i    (dma_wready_i),
      .pix_i       (conv_pix),
      .pix_valid_i (conv_valid),
      .hold_o      (out_hold),
      .beat_o      (dma_beat_o),
      .overflow_o  (out_ovf),
      .pop_o       (out_pop)
   );

   // strobes gathered for the register block
   assign events.in_push      = stream_wr_en_i;
   assign events.in_overflow  = in_ovf;
   assign events.out_overflow = out_ovf;
   assign events.out_pop      = out_pop;

   ////////////////////
   // control
   ////////////////////
   accel_regs u_regs (
      .clk      (clk),
      .rst      (rst),
      .wr_i     (reg_wr_i),
      .re_i     (reg_re_i),
      .raddr_i  (reg_raddr_i),
      .rdata_o  (reg_rdata_o),
      .rvalid_o (reg_rvalid_o),
      .events_i (events),
      .mode_o   (mode),
      .start_o  (start)
   );

endmodule

`default_nettype wire

//--- logic/pixel_unpacker.sv
// input FIFO of two-pixel words, one pixel out per cycle
// hold_i stalls the output; writes on a full FIFO are dropped
`timescale 1ns/1ns
`default_nettype none

`include "accel_consts.svh"

module pixel_unpacker (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         flush_i,
   input  logic                         push_i,
   input  stream_types_pkg::stream_word_t word_i,
   input  logic                         hold_i,
   output stream_types_pkg::pixel_t     pix_o,
   output logic                         pix_valid_o,
   output logic                         overflow_o
);

   stream_types_pkg::stream_word_t head_word;
   logic                           fifo_empty;
   logic                           fifo_pop;
   // 0 = lo half, 1 = hi half
   logic                           half_sel;

   sync_fifo #(
      .WIDTH ($bits(stream_types_pkg::stream_word_t)),
      .DEPTH (`ACCEL_IN_DEPTH)
   ) u_in_fifo (
      .clk        (clk),
      .rst        (rst),
      .flush_i    (flush_i),
      .push_i     (push_i),
      .pop_i      (fifo_pop),
      .wdata_i    (word_i),
      .rdata_o    (head_word),
      .empty_o    (fifo_empty),
      .count_o    (),
      .overflow_o (overflow_o)
   );

   // one pixel per cycle unless downstream is near full
   assign pix_valid_o = !fifo_empty && !hold_i;
   assign pix_o       = half_sel ? head_word.hi : head_word.lo;
   // word retires once its hi half has gone
   assign fifo_pop    = pix_valid_o && half_sel;

   ////////////////////
   // half select
   ////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         half_sel <= 1'b0;
      end else if (flush_i) begin
         half_sel <= 1'b0;
      end else if (pix_valid_o) begin
         half_sel <= !half_sel;
      end
   end

endmodule

`default_nettype wire

//--- logic/stream_types_pkg.sv
// datapath types: pixels, stream words and DMA beats
`default_nettype none

`include "accel_consts.svh"

package stream_types_pkg;

   // r is the top byte
   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } pixel_t;

   // lo goes out first
   typedef struct packed {
      pixel_t hi;
      pixel_t lo;
   } stream_word_t;

   // wdata is the pixel with a zero byte on top
   typedef struct packed {
      logic                    wvalid;
      logic                    wlast;
      logic [`ACCEL_DMA_W-1:0] wdata;
   } dma_beat_t;

endpackage

`default_nettype wire

//--- logic/sync_fifo.sv
// first-word-fall-through ring buffer, DEPTH must be a power of two
// no back-pressure: a push into a full buffer is lost and flagged
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   flush_i,
   input  logic                   push_i,
   input  logic                   pop_i,
   input  logic [WIDTH-1:0]       wdata_i,
   output logic [WIDTH-1:0]       rdata_o,
   output logic                   empty_o,
   output logic [$clog2(DEPTH):0] count_o,
   output logic                   overflow_o
);

   localparam int AW = $clog2(DEPTH);

   // storage, no reset needed
   logic [WIDTH-1:0] mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign full       = (count == (AW+1)'(DEPTH));
   assign empty_o    = (count == '0);
   assign do_push    = push_i && !full;
   // pop on empty is ignored
   assign do_pop     = pop_i && !empty_o;
   assign overflow_o = push_i && full;
   // head word always visible
   assign rdata_o    = mem[rd_ptr];
   assign count_o    = count;

   // pointers and fill count
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush_i) begin
         // synchronous empty, contents left stale
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= wdata_i;
   end

endmodule

`default_nettype wire
